/* design/dc_defs.svh */
// data cache controller sizes
`ifndef DC_DEFS_SVH
`define DC_DEFS_SVH

`define DC_ADDR_W 36  // line address
`define DC_DATA_W 64
`define DC_BE_W 8
`define DC_TAG_W 5    // request tag
`define DC_ID_W 5     // node id

`define DC_WQ_DEPTH 16
`define DC_RQ_DEPTH 16
// miss queue depth, also miss table entries
`define DC_MQ_DEPTH 24

`define DC_STALL_CNT 12   // write queue near-full point
`define DC_BUS_CREDITS 4  // credits after reset

`endif

/* design/dc_pkg.sv */
// data cache controller types
`default_nettype none

`include "dc_defs.svh"

package dc_pkg;

  // write queue entry
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_DATA_W-1:0] data;
    logic [`DC_BE_W-1:0]   be;
  } write_req_t;

  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_TAG_W-1:0]  tag;
    logic                  excl;
  } read_req_t;

  // miss queue entry, goes out on the bus
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_TAG_W-1:0]  tag;
    logic                  excl;
  } miss_req_t;

  // cache port operation
  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_write = 2'd1,
    op_read  = 2'd2,
    op_fill  = 2'd3
  } port_op_t;

endpackage

`default_nettype wire

/* design/dc_queue.sv */
// circular request queue
`timescale 1ns/100ps
`default_nettype none

module dc_queue #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16,
  parameter int  STALL_AT  = 12
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      push,
  input  payload_t push_data,
  input  wire      pop,
  output payload_t head,
  output logic     valid,
  output logic     near_full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  assign head      = mem[rd_ptr];  // fall-through head
  assign valid     = count != '0;
  assign near_full = count >= CNT_W'(STALL_AT);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      if (push && !pop)
        count <= count + CNT_W'(1);
      else if (pop && !push)
        count <= count - CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

/* design/dc_miss_table.sv */
// miss address table and reply capture
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module dc_miss_table #(
  parameter logic [`DC_ID_W-1:0] NODE_ID = '0
) (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             miss_en,
  input  wire  [`DC_ADDR_W-1:0]           miss_addr,
  input  wire  [`DC_TAG_W-1:0]            miss_tag,
  input  wire                             rsp_valid,
  input  wire  [`DC_ID_W+`DC_TAG_W-1:0]   rsp_dst,
  input  wire  [`DC_DATA_W-1:0]           rsp_data,
  output logic                            fill_valid,
  output logic [`DC_ADDR_W-1:0]           fill_addr,
  output logic [`DC_DATA_W-1:0]           fill_data,
  output logic [`DC_TAG_W-1:0]            fill_tag
);

  logic [`DC_ADDR_W-1:0] addr_tbl [`DC_MQ_DEPTH];
  logic                  rsp_hit_q;  // reply is ours
  logic [`DC_TAG_W-1:0]  rsp_tag_q;
  logic [`DC_DATA_W-1:0] rsp_data_q;

  always_ff @(posedge clk)
  begin
    if (miss_en)
      addr_tbl[miss_tag] <= miss_addr;
    rsp_tag_q  <= rsp_dst[`DC_TAG_W-1:0];
    rsp_data_q <= rsp_data;
    fill_addr  <= addr_tbl[rsp_tag_q];  // lookup one edge after capture
    fill_data  <= rsp_data_q;
    fill_tag   <= rsp_tag_q;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rsp_hit_q  <= 1'b0;
      fill_valid <= 1'b0;
    end
    else
    begin
      rsp_hit_q  <= rsp_valid && (rsp_dst[`DC_ID_W+`DC_TAG_W-1 -: `DC_ID_W] == NODE_ID);
      fill_valid <= rsp_hit_q;
    end
  end

endmodule

`default_nettype wire

/* design/dc_miss_issue.sv */
// miss queue and bus request issue
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module dc_miss_issue #(
  parameter logic [`DC_ID_W-1:0] NODE_ID = '0
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           miss_en,
  input  wire  [`DC_ADDR_W-1:0]         miss_addr,
  input  wire  [`DC_TAG_W-1:0]          miss_tag,
  input  wire                           miss_excl,
  input  wire                           bus_credit_return,
  output logic                          bus_req_valid,
  output logic [`DC_ADDR_W-1:0]         bus_req_addr,
  output logic [`DC_ID_W+`DC_TAG_W-1:0] bus_req_src,
  output logic                          bus_req_excl
);
  import dc_pkg::*;

  localparam int CRED_W = $clog2(`DC_BUS_CREDITS + 1);

  miss_req_t          miss_in;
  miss_req_t          miss_head;
  logic               miss_valid;
  logic               issue;
  logic [CRED_W-1:0]  credits;

  assign miss_in = '{addr: miss_addr, tag: miss_tag, excl: miss_excl};

  dc_queue #(
    .payload_t (miss_req_t),
    .DEPTH     (`DC_MQ_DEPTH),
    .STALL_AT  (`DC_MQ_DEPTH)
  ) u_miss_q (
    .clk       (clk),
    .rst       (rst),
    .push      (miss_en),
    .push_data (miss_in),
    .pop       (issue),
    .head      (miss_head),
    .valid     (miss_valid),
    .near_full ()
  );

  assign issue         = miss_valid && (credits != '0);  // one per cycle
  assign bus_req_valid = issue;
  assign bus_req_addr  = miss_head.addr;
  assign bus_req_src   = {NODE_ID, miss_head.tag};
  assign bus_req_excl  = miss_head.excl;

  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= CRED_W'(`DC_BUS_CREDITS);
    else if (issue && !bus_credit_return)
      credits <= credits - CRED_W'(1);
    else if (bus_credit_return && !issue)
      credits <= credits + CRED_W'(1);
  end

endmodule

`default_nettype wire

/* design/dc_port_arbiter.sv */
// cache port priority arbiter
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module dc_port_arbiter (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     fill_valid,
  input  wire  [`DC_ADDR_W-1:0]   fill_addr,
  input  wire  [`DC_DATA_W-1:0]   fill_data,
  input  wire  [`DC_TAG_W-1:0]    fill_tag,
  input  wire                     rd_valid,
  input  dc_pkg::read_req_t       rd_head,
  output logic                    rd_pop,
  input  wire                     wr_valid,
  input  dc_pkg::write_req_t      wr_head,
  output logic                    wr_pop,
  output dc_pkg::port_op_t        port_op,
  output logic [`DC_ADDR_W-1:0]   port_addr,
  output logic [`DC_DATA_W-1:0]   port_data,
  output logic [`DC_BE_W-1:0]     port_be,
  output logic [`DC_TAG_W-1:0]    port_tag,
  output logic                    port_excl
);
  import dc_pkg::*;

  port_op_t              op_d;
  logic [`DC_ADDR_W-1:0] addr_d;
  logic [`DC_DATA_W-1:0] data_d;
  logic [`DC_BE_W-1:0]   be_d;
  logic [`DC_TAG_W-1:0]  tag_d;
  logic                  excl_d;

  // fill never waits, read beats write
  assign rd_pop = rd_valid && !fill_valid;
  assign wr_pop = wr_valid && !fill_valid && !rd_valid;

  always_comb
  begin
    op_d   = op_none;
    addr_d = wr_head.addr;
    data_d = wr_head.data;
    be_d   = wr_head.be;
    tag_d  = '0;
    excl_d = 1'b0;
    if (fill_valid)
    begin
      op_d   = op_fill;
      addr_d = fill_addr;
      data_d = fill_data;
      be_d   = '1;  // whole line
      tag_d  = fill_tag;
    end
    else if (rd_valid)
    begin
      op_d   = op_read;
      addr_d = rd_head.addr;
      data_d = '0;
      be_d   = '0;
      tag_d  = rd_head.tag;
      excl_d = rd_head.excl;
    end
    else if (wr_valid)
      op_d = op_write;
  end

  always_ff @(posedge clk)
  begin
    port_addr <= addr_d;
    port_data <= data_d;
    port_be   <= be_d;
    port_tag  <= tag_d;
    port_excl <= excl_d;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      port_op <= op_none;
    else
      port_op <= op_d;
  end

endmodule

`default_nettype wire

/* design/dc_cntrl_top.sv */
// data cache request controller
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module dc_cntrl_top #(
  parameter logic [`DC_ID_W-1:0] NODE_ID = '0
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           wr_en,
  input  wire  [`DC_ADDR_W-1:0]         wr_addr,
  input  wire  [`DC_DATA_W-1:0]         wr_data,
  input  wire  [`DC_BE_W-1:0]           wr_be,
  output logic                          wq_stall,
  input  wire                           rd_en,
  input  wire  [`DC_ADDR_W-1:0]         rd_addr,
  input  wire  [`DC_TAG_W-1:0]          rd_tag,
  input  wire                           rd_excl,
  input  wire                           miss_en,
  input  wire  [`DC_ADDR_W-1:0]         miss_addr,
  input  wire  [`DC_TAG_W-1:0]          miss_tag,
  input  wire                           miss_excl,
  output logic                          bus_req_valid,
  output logic [`DC_ADDR_W-1:0]         bus_req_addr,
  output logic [`DC_ID_W+`DC_TAG_W-1:0] bus_req_src,
  output logic                          bus_req_excl,
  input  wire                           bus_credit_return,
  input  wire                           rsp_valid,
  input  wire  [`DC_ID_W+`DC_TAG_W-1:0] rsp_dst,
  input  wire  [`DC_DATA_W-1:0]         rsp_data,
  output dc_pkg::port_op_t              port_op,
  output logic [`DC_ADDR_W-1:0]         port_addr,
  output logic [`DC_DATA_W-1:0]         port_data,
  output logic [`DC_BE_W-1:0]           port_be,
  output logic [`DC_TAG_W-1:0]          port_tag,
  output logic                          port_excl
);
  import dc_pkg::*;

  write_req_t            wr_in, wr_head;
  read_req_t             rd_in, rd_head;
  logic                  wr_valid, wr_pop;
  logic                  rd_valid, rd_pop;
  logic                  fill_valid;
  logic [`DC_ADDR_W-1:0] fill_addr;
  logic [`DC_DATA_W-1:0] fill_data;
  logic [`DC_TAG_W-1:0]  fill_tag;

  assign wr_in = '{addr: wr_addr, data: wr_data, be: wr_be};
  assign rd_in = '{addr: rd_addr, tag: rd_tag, excl: rd_excl};

  dc_queue #(.payload_t(write_req_t), .DEPTH(`DC_WQ_DEPTH), .STALL_AT(`DC_STALL_CNT)) u_wr_q (
    .clk(clk), .rst(rst), .push(wr_en), .push_data(wr_in), .pop(wr_pop),
    .head(wr_head), .valid(wr_valid), .near_full(wq_stall)
  );

  // read queue never stalls upstream
  dc_queue #(.payload_t(read_req_t), .DEPTH(`DC_RQ_DEPTH), .STALL_AT(`DC_RQ_DEPTH)) u_rd_q (
    .clk(clk), .rst(rst), .push(rd_en), .push_data(rd_in), .pop(rd_pop),
    .head(rd_head), .valid(rd_valid), .near_full()
  );

  dc_miss_table #(.NODE_ID(NODE_ID)) u_miss_tbl (
    .clk(clk), .rst(rst), .miss_en(miss_en), .miss_addr(miss_addr), .miss_tag(miss_tag),
    .rsp_valid(rsp_valid), .rsp_dst(rsp_dst), .rsp_data(rsp_data),
    .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
    .fill_tag(fill_tag)
  );

  dc_miss_issue #(.NODE_ID(NODE_ID)) u_miss_issue (
    .clk(clk), .rst(rst), .miss_en(miss_en), .miss_addr(miss_addr), .miss_tag(miss_tag),
    .miss_excl(miss_excl), .bus_credit_return(bus_credit_return),
    .bus_req_valid(bus_req_valid), .bus_req_addr(bus_req_addr),
    .bus_req_src(bus_req_src), .bus_req_excl(bus_req_excl)
  );

  dc_port_arbiter u_arb (
    .clk(clk), .rst(rst),
    .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
    .fill_tag(fill_tag),
    .rd_valid(rd_valid), .rd_head(rd_head), .rd_pop(rd_pop),
    .wr_valid(wr_valid), .wr_head(wr_head), .wr_pop(wr_pop),
    .port_op(port_op), .port_addr(port_addr), .port_data(port_data),
    .port_be(port_be), .port_tag(port_tag), .port_excl(port_excl)
  );

endmodule

`default_nettype wire

/* testbench/dc_asserts.sv */
// cache controller assertions
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module dc_asserts (
  input wire              clk,
  input wire              rst,
  input wire              fill_valid,
  input wire              rd_pop,
  input wire              wr_pop,
  input wire              bus_req_valid,
  input wire              bus_credit_return,
  input dc_pkg::port_op_t port_op
);
  import dc_pkg::*;

  int outstanding;  // bus requests holding a credit
  int fails = 0;

  always_ff @(posedge clk)
  begin
    if (rst)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(bus_req_valid) - int'(bus_credit_return);
  end

  a_reset_idle: assert property (@(posedge clk) rst |=> port_op == op_none && !bus_req_valid)
    else
    begin
      $error("cache port or bus request active right after reset");
      fails++;
    end

  a_fill_first: assert property (@(posedge clk) disable iff (rst)
    fill_valid |=> port_op == op_fill)
    else
    begin
      $error("pending fill did not win the cache port");
      fails++;
    end

  // a popped entry must reach the port as its own op
  a_read_pop: assert property (@(posedge clk) disable iff (rst)
    rd_pop |=> port_op == op_read)
    else
    begin
      $error("popped read did not reach the cache port");
      fails++;
    end

  a_write_pop: assert property (@(posedge clk) disable iff (rst)
    wr_pop |=> port_op == op_write)
    else
    begin
      $error("popped write did not reach the cache port");
      fails++;
    end

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    outstanding <= `DC_BUS_CREDITS && (bus_req_valid -> outstanding < `DC_BUS_CREDITS))
    else
    begin
      $error("bus requests outstanding beyond the credits held");
      fails++;
    end

endmodule

// bus signals only exist at the top
bind dc_cntrl_top dc_asserts u_asserts (
  .clk(clk), .rst(rst), .fill_valid(fill_valid), .rd_pop(rd_pop), .wr_pop(wr_pop),
  .bus_req_valid(bus_req_valid), .bus_credit_return(bus_credit_return), .port_op(port_op)
);

bind dc_port_arbiter dc_asserts u_asserts (
  .clk(clk), .rst(rst), .fill_valid(fill_valid), .rd_pop(rd_pop), .wr_pop(wr_pop),
  .bus_req_valid(1'b0), .bus_credit_return(1'b0), .port_op(port_op)
);

`default_nettype wire

/* testbench/tb_checker.sv */
// reference model and port checks
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module tb_checker #(
  parameter logic [`DC_ID_W-1:0] NODE_ID = '0
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           wr_en,
  input  wire  [`DC_ADDR_W-1:0]         wr_addr,
  input  wire  [`DC_DATA_W-1:0]         wr_data,
  input  wire  [`DC_BE_W-1:0]           wr_be,
  input  wire                           wq_stall,
  input  wire                           rd_en,
  input  wire  [`DC_ADDR_W-1:0]         rd_addr,
  input  wire  [`DC_TAG_W-1:0]          rd_tag,
  input  wire                           rd_excl,
  input  wire                           miss_en,
  input  wire  [`DC_ADDR_W-1:0]         miss_addr,
  input  wire  [`DC_TAG_W-1:0]          miss_tag,
  input  wire                           miss_excl,
  input  wire                           bus_req_valid,
  input  wire  [`DC_ADDR_W-1:0]         bus_req_addr,
  input  wire  [`DC_ID_W+`DC_TAG_W-1:0] bus_req_src,
  input  wire                           bus_req_excl,
  input  wire                           rsp_valid,
  input  wire  [`DC_ID_W+`DC_TAG_W-1:0] rsp_dst,
  input  wire  [`DC_DATA_W-1:0]         rsp_data,
  input  dc_pkg::port_op_t              port_op,
  input  wire  [`DC_ADDR_W-1:0]         port_addr,
  input  wire  [`DC_DATA_W-1:0]         port_data,
  input  wire  [`DC_BE_W-1:0]           port_be,
  input  wire  [`DC_TAG_W-1:0]          port_tag,
  input  wire                           port_excl,
  output logic                          drained,
  output int                            errors
);
  import dc_pkg::*;

  write_req_t            exp_wr[$];
  read_req_t             exp_rd[$];
  miss_req_t             exp_miss[$];
  logic [`DC_ADDR_W-1:0] tag_addr [`DC_MQ_DEPTH];  // address recorded per miss tag
  int                    wr_count = 0;
  int                    checks = 0;
  // reply to fill pipeline, stage 2 is due on the port now
  logic                  fill_v [3];
  logic [`DC_ADDR_W-1:0] fill_a [3];
  logic [`DC_DATA_W-1:0] fill_d [3];
  logic [`DC_TAG_W-1:0]  fill_t [3];

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("** Error %s at %0t: expected %0h actual %0h", name, $time, exp, act);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic print_summary(input int assert_fails, input bit timed_out);
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, assert_fails, timed_out);
  endtask

  // sample at the falling edge, everything is settled
  always @(negedge clk)
  begin
    write_req_t w;
    read_req_t  r;
    miss_req_t  m;
    if (rst)
    begin
      check_val("reset port_op", 128'(op_none), 128'(port_op));
      check_val("reset bus_req_valid", 128'(0), 128'(bus_req_valid));
      check_val("reset wq_stall", 128'(0), 128'(wq_stall));
      exp_wr.delete();
      exp_rd.delete();
      exp_miss.delete();
      wr_count = 0;
      fill_v = '{default: 1'b0};
    end
    else
    begin
      if (port_op == op_write)
      begin
        if (exp_wr.size() == 0)
          report_fail("write on cache port with no accepted write left");
        else
        begin
          w = exp_wr.pop_front();
          check_val("write addr", 128'(w.addr), 128'(port_addr));
          check_val("write data", 128'(w.data), 128'(port_data));
          check_val("write be", 128'(w.be), 128'(port_be));
          wr_count--;
        end
      end
      if (port_op == op_read)
      begin
        if (exp_rd.size() == 0)
          report_fail("read on cache port with no accepted read left");
        else
        begin
          r = exp_rd.pop_front();
          check_val("read addr", 128'(r.addr), 128'(port_addr));
          check_val("read tag", 128'(r.tag), 128'(port_tag));
          check_val("read excl", 128'(r.excl), 128'(port_excl));
          check_val("read data", 128'(0), 128'(port_data));
        end
      end
      if (fill_v[2] && port_op == op_fill)
      begin
        check_val("fill addr", 128'(fill_a[2]), 128'(port_addr));
        check_val("fill data", 128'(fill_d[2]), 128'(port_data));
        check_val("fill tag", 128'(fill_t[2]), 128'(port_tag));
        check_val("fill be", 128'({`DC_BE_W{1'b1}}), 128'(port_be));
      end
      else if (fill_v[2])
        report_fail("reply to this node gave no fill three cycles later");
      else if (port_op == op_fill)
        report_fail("fill on cache port without a matching reply");
      check_val("wq_stall", 128'(wr_count >= `DC_STALL_CNT), 128'(wq_stall));
      if (bus_req_valid)
      begin
        if (exp_miss.size() == 0)
          report_fail("bus request with no miss behind it");
        else
        begin
          m = exp_miss.pop_front();
          check_val("bus addr", 128'(m.addr), 128'(bus_req_addr));
          check_val("bus src", 128'({NODE_ID, m.tag}), 128'(bus_req_src));
          check_val("bus excl", 128'(m.excl), 128'(bus_req_excl));
        end
      end
      for (int i = 2; i > 0; i--)
      begin
        fill_v[i] = fill_v[i-1];
        fill_a[i] = fill_a[i-1];
        fill_d[i] = fill_d[i-1];
        fill_t[i] = fill_t[i-1];
      end
      fill_v[0] = rsp_valid && rsp_dst[`DC_ID_W+`DC_TAG_W-1 -: `DC_ID_W] == NODE_ID;
      fill_a[0] = tag_addr[rsp_dst[`DC_TAG_W-1:0]];
      fill_d[0] = rsp_data;
      fill_t[0] = rsp_dst[`DC_TAG_W-1:0];
      // inputs accepted at the coming edge
      if (wr_en)
      begin
        exp_wr.push_back('{addr: wr_addr, data: wr_data, be: wr_be});
        wr_count++;
      end
      if (rd_en)
        exp_rd.push_back('{addr: rd_addr, tag: rd_tag, excl: rd_excl});
      if (miss_en)
      begin
        exp_miss.push_back('{addr: miss_addr, tag: miss_tag, excl: miss_excl});
        tag_addr[miss_tag] = miss_addr;
      end
    end
    drained = exp_wr.size() == 0 && exp_rd.size() == 0 && exp_miss.size() == 0 &&
              !fill_v[0] && !fill_v[1] && !fill_v[2];
  end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
// data cache controller testbench
`timescale 1ns/100ps
`default_nettype none

`include "dc_defs.svh"

module tb_top;
  import dc_pkg::*;

  localparam logic [`DC_ID_W-1:0] NODE = 5'd3;
  localparam int RUN_CYCLES  = 2000;
  localparam int DRAIN_LIMIT = 3000;

  logic clk = 1'b0;
  logic rst;
  logic wr_en, rd_en, rd_excl, miss_en, miss_excl, bus_credit_return, rsp_valid;
  logic [`DC_ADDR_W-1:0] wr_addr, rd_addr, miss_addr;
  logic [`DC_DATA_W-1:0] wr_data, rsp_data;
  logic [`DC_BE_W-1:0] wr_be;
  logic [`DC_TAG_W-1:0] rd_tag, miss_tag;
  logic [`DC_ID_W+`DC_TAG_W-1:0] rsp_dst;
  logic wq_stall, bus_req_valid, bus_req_excl, port_excl;
  logic [`DC_ADDR_W-1:0] bus_req_addr, port_addr;
  logic [`DC_ID_W+`DC_TAG_W-1:0] bus_req_src;
  port_op_t port_op;
  logic [`DC_DATA_W-1:0] port_data;
  logic [`DC_BE_W-1:0] port_be;
  logic [`DC_TAG_W-1:0] port_tag;
  logic drained;
  int chk_errors;

  int seed = 67;
  int cycle = 0;
  logic stim_on;
  int rd_pending = 0;
  logic [`DC_MQ_DEPTH-1:0] tag_busy = '0;  // miss tags waiting for a fill
  int credit_due[$];
  int rsp_due_q[$];
  logic [`DC_TAG_W-1:0] rsp_tag_q[$];

  dc_cntrl_top #(.NODE_ID(NODE)) u_dut (.*);

  tb_checker #(.NODE_ID(NODE)) u_chk (.errors(chk_errors), .*);

  always #10 clk = ~clk;

  function automatic logic [31:0] rnd32();
    return $random(seed);
  endfunction

  function automatic bit all_idle();
    return drained && tag_busy == '0 && rsp_due_q.size() == 0;
  endfunction

  // bus agent and request stimulus, 1 ns after the edge
  always @(posedge clk)
  begin
    logic [31:0] r0, r1, r2, r3, r4;
    int pick;
    #1;
    cycle++;
    r0 = rnd32();
    r1 = rnd32();
    r2 = rnd32();
    r3 = rnd32();
    r4 = rnd32();
    if (port_op == op_read && rd_pending > 0)
      rd_pending--;
    if (port_op == op_fill)
      tag_busy[port_tag] = 1'b0;
    if (bus_req_valid)
    begin
      credit_due.push_back(cycle + 1 + int'(r0[2:0]));
      rsp_tag_q.push_back(bus_req_src[`DC_TAG_W-1:0]);
      rsp_due_q.push_back(cycle + 2 + int'(r0[7:3]));
    end
    bus_credit_return = 1'b0;
    if (credit_due.size() > 0 && credit_due[0] <= cycle)
    begin
      bus_credit_return = 1'b1;
      void'(credit_due.pop_front());
    end
    rsp_valid = 1'b0;
    rsp_dst   = '0;
    rsp_data  = {r1, r2};
    pick = -1;
    foreach (rsp_due_q[i])
      if (pick < 0 && rsp_due_q[i] <= cycle)
        pick = i;
    if (pick >= 0)
    begin
      rsp_valid = 1'b1;
      rsp_dst   = {NODE, rsp_tag_q[pick]};
      rsp_tag_q.delete(pick);
      rsp_due_q.delete(pick);
    end
    else if (r0[12:9] == 4'd0)
    begin
      rsp_valid = 1'b1;  // some other node's reply
      rsp_dst   = {(r0[13] ? 5'd4 : 5'd17), r2[4:0] % 5'd24};
    end
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    miss_en   = 1'b0;
    wr_addr   = {r3[3:0], r4};
    wr_data   = {r4, r3};
    wr_be     = r1[7:0];
    rd_addr   = {r4[3:0], r3};
    rd_tag    = r2[4:0];
    rd_excl   = r2[5];
    miss_addr = {r2[3:0], r1};
    miss_tag  = 5'(r1[7:0] % 8'd24);
    miss_excl = r3[31];
    if (stim_on && !rst)
    begin
      // alternate light and heavy load so the write queue fills up
      wr_en = !wq_stall && (cycle[8] ? r0[15:14] != 2'd0 : r0[15:14] == 2'd0);
      rd_en = rd_pending < `DC_RQ_DEPTH - 4 && (cycle[8] ? r0[16] : r0[17:16] == 2'd0);
      if (rd_en)
        rd_pending++;
      miss_en = !tag_busy[miss_tag] && r0[18];
      if (miss_en)
        tag_busy[miss_tag] = 1'b1;
    end
  end

  initial
  begin
    int wait_cnt;
    int assert_fails;
    bit timed_out;
    rst = 1'b1;
    stim_on = 1'b0;
    {wr_en, rd_en, rd_excl, miss_en, miss_excl, bus_credit_return, rsp_valid} = '0;
    {wr_addr, rd_addr, miss_addr, wr_data, rsp_data} = '0;
    {wr_be, rd_tag, miss_tag, rsp_dst} = '0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk) stim_on = 1'b1;
    repeat (RUN_CYCLES) @(posedge clk);
    @(negedge clk) stim_on = 1'b0;
    wait_cnt = 0;
    while (!all_idle() && wait_cnt < DRAIN_LIMIT)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    timed_out = !all_idle();
    if (timed_out)
      $display("timeout: requests still in flight %0d cycles after stimulus ended", DRAIN_LIMIT);
    assert_fails = u_dut.u_asserts.fails + u_dut.u_arb.u_asserts.fails;
    u_chk.print_summary(assert_fails, timed_out);
    if (chk_errors == 0 && assert_fails == 0 && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/dc_pkg.sv
design/dc_queue.sv
design/dc_miss_table.sv
design/dc_miss_issue.sv
design/dc_port_arbiter.sv
design/dc_cntrl_top.sv
testbench/dc_asserts.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Makefile */
SIM := obj_dir/Vtb_top

.PHONY: all run lint clean

all: run

$(SIM): project.f $(wildcard design/*.sv design/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f project.f --top-module tb_top -o Vtb_top

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module tb_top

clean:
	rm -rf obj_dir sim.log
